// File: sim.f
rtl/axi_mem_pkg.sv
rtl/mem_port_if.sv
rtl/mem_bank_if.sv
rtl/mem_bank.sv
rtl/mem_bank_xbar.sv
rtl/axi_mem_adapter.sv
rtl/axi_mem_banked_top.sv
verification/axi_mem_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
LINTFLAGS ?= --lint-only -Wall --timing
TOP       := axi_mem_tb
RTL_TOP   := axi_mem_banked_top
FILELIST  := sim.f
OBJ_DIR   := obj_dir
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q '>>> FAIL' $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q '>>> PASS' $(LOG); then echo "Simulation ended without a result"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verification/axi_mem_tb.sv
// AXI banked memory testbench
`default_nettype none

module axi_mem_tb;

  localparam logic [31:0] SEED    = 32'h242b2b6d;
  localparam int unsigned N_FILL  = 16;
  localparam int unsigned N_MERGE = 16;
  localparam int unsigned N_CONC  = 16;
  // Two concurrent rounds, one without and one with ready stalls
  localparam int unsigned N_WRITES       = N_FILL + N_MERGE + 2 * N_CONC;
  // Each concurrent round also reads its upper rows back
  localparam int unsigned N_READS        = N_FILL + N_MERGE + 4 * N_CONC;
  localparam int unsigned NUM_TXN        = N_WRITES + N_READS;
  localparam int unsigned TIMEOUT_CYCLES = 40 * NUM_TXN + 200;

  logic                                   clk_i;
  logic                                   rst_n_i;
  logic                                   awvalid_i;
  logic                                   awready_o;
  logic [axi_mem_pkg::AXI_ID_WIDTH-1:0]   awid_i;
  logic [axi_mem_pkg::AXI_ADDR_WIDTH-1:0] awaddr_i;
  logic                                   wvalid_i;
  logic                                   wready_o;
  logic [axi_mem_pkg::AXI_DATA_WIDTH-1:0] wdata_i;
  logic [axi_mem_pkg::AXI_STRB_WIDTH-1:0] wstrb_i;
  logic                                   bvalid_o;
  logic                                   bready_i;
  logic [axi_mem_pkg::AXI_ID_WIDTH-1:0]   bid_o;
  logic [1:0]                             bresp_o;
  logic                                   arvalid_i;
  logic                                   arready_o;
  logic [axi_mem_pkg::AXI_ID_WIDTH-1:0]   arid_i;
  logic [axi_mem_pkg::AXI_ADDR_WIDTH-1:0] araddr_i;
  logic                                   rvalid_o;
  logic                                   rready_i;
  logic [axi_mem_pkg::AXI_ID_WIDTH-1:0]   rid_o;
  logic [axi_mem_pkg::AXI_DATA_WIDTH-1:0] rdata_o;
  logic [1:0]                             rresp_o;
  logic [1:0]                             busy_o;

  // Byte image of the whole address space, unknown until written
  logic [7:0] shadow [1 << axi_mem_pkg::AXI_ADDR_WIDTH];

  // Expected responses in acceptance order
  logic [axi_mem_pkg::AXI_ID_WIDTH-1:0]   exp_bid_q [$];
  logic [axi_mem_pkg::AXI_ID_WIDTH-1:0]   exp_rid_q [$];
  logic [axi_mem_pkg::AXI_DATA_WIDTH-1:0] exp_rdata_q [$];

  logic [axi_mem_pkg::AXI_ADDR_WIDTH-1:0] fill_addr [N_FILL];
  logic [31:0] rng_q;
  logic [31:0] stall_q;
  logic        stall_en;
  logic        wr_out;
  logic        rd_out;
  int          aw_cnt, b_cnt, ar_cnt, r_cnt;
  int          data_err, id_err, resp_err, busy_err, other_err;
  int          cycle_cnt;

  // Previous cycle of B and R for the hold check
  logic                                   prev_bvalid, prev_bready, prev_rvalid, prev_rready;
  logic [axi_mem_pkg::AXI_ID_WIDTH-1:0]   prev_bid, prev_rid;
  logic [axi_mem_pkg::AXI_DATA_WIDTH-1:0] prev_rdata;

  // Signal names match the DUT ports
  axi_mem_banked_top i_axi_mem_banked_top (.*);

  always begin
    clk_i = 1'b0;
    #10;
    clk_i = 1'b1;
    #10;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic draw_rand(output logic [31:0] value);
    rng_q = xorshift32(rng_q);
    value = rng_q;
  endtask

  // Beat spans eight bytes starting at the low bank of its pair
  function automatic logic [axi_mem_pkg::AXI_DATA_WIDTH-1:0] ref_read(
      input logic [axi_mem_pkg::AXI_ADDR_WIDTH-1:0] addr);
    axi_mem_pkg::axi_addr_u                 a;
    logic [axi_mem_pkg::AXI_ADDR_WIDTH-1:0] base;
    logic [axi_mem_pkg::AXI_DATA_WIDTH-1:0] word;
    a.flat = addr;
    base   = {a.fields.row, a.fields.bank[1], 3'b000};
    for (int i = 0; i < 8; i++) begin
      word[8*i +: 8] = shadow[base + 12'(i)];
    end
    return word;
  endfunction

  // Only strobed bytes change
  task automatic merge_write(input logic [axi_mem_pkg::AXI_ADDR_WIDTH-1:0] addr,
                             input logic [axi_mem_pkg::AXI_DATA_WIDTH-1:0] data,
                             input logic [axi_mem_pkg::AXI_STRB_WIDTH-1:0] strb);
    logic [axi_mem_pkg::AXI_ADDR_WIDTH-1:0] base;
    base = {addr[axi_mem_pkg::AXI_ADDR_WIDTH-1:3], 3'b000};
    for (int i = 0; i < 8; i++) begin
      if (strb[i]) begin
        shadow[base + 12'(i)] = data[8*i +: 8];
      end
    end
  endtask

  task automatic check_data(input string name,
                            input logic [axi_mem_pkg::AXI_DATA_WIDTH-1:0] exp,
                            input logic [axi_mem_pkg::AXI_DATA_WIDTH-1:0] act);
    if (act !== exp) begin
      data_err++;
      $display("FAILED %s expected %h actual %h at %0t", name, exp, act, $time);
    end
  endtask

  task automatic check_id(input string name,
                          input logic [axi_mem_pkg::AXI_ID_WIDTH-1:0] exp,
                          input logic [axi_mem_pkg::AXI_ID_WIDTH-1:0] act);
    if (act !== exp) begin
      id_err++;
      $display("FAILED %s expected %h actual %h at %0t", name, exp, act, $time);
    end
  endtask

  task automatic check_resp(input string name, input logic [1:0] exp, input logic [1:0] act);
    if (act !== exp) begin
      resp_err++;
      $display("FAILED %s expected %h actual %h at %0t", name, exp, act, $time);
    end
  endtask

  task automatic check_busy(input string name, input logic [1:0] exp, input logic [1:0] act);
    if (act !== exp) begin
      busy_err++;
      $display("FAILED %s expected %h actual %h at %0t", name, exp, act, $time);
    end
  endtask

  // AW and W presented together and held until taken
  task automatic write_beat(input logic [axi_mem_pkg::AXI_ADDR_WIDTH-1:0] addr,
                            input logic [axi_mem_pkg::AXI_DATA_WIDTH-1:0] data,
                            input logic [axi_mem_pkg::AXI_STRB_WIDTH-1:0] strb,
                            input logic [axi_mem_pkg::AXI_ID_WIDTH-1:0]   id);
    @(negedge clk_i);
    awvalid_i = 1'b1;
    awid_i    = id;
    awaddr_i  = addr;
    wvalid_i  = 1'b1;
    wdata_i   = data;
    wstrb_i   = strb;
    @(posedge clk_i);
    while (!(awready_o && wready_o)) @(posedge clk_i);
    @(negedge clk_i);
    awvalid_i = 1'b0;
    wvalid_i  = 1'b0;
  endtask

  task automatic read_beat(input logic [axi_mem_pkg::AXI_ADDR_WIDTH-1:0] addr,
                           input logic [axi_mem_pkg::AXI_ID_WIDTH-1:0]   id);
    @(negedge clk_i);
    arvalid_i = 1'b1;
    arid_i    = id;
    araddr_i  = addr;
    @(posedge clk_i);
    while (!arready_o) @(posedge clk_i);
    @(negedge clk_i);
    arvalid_i = 1'b0;
  endtask

  task automatic wait_all_done();
    while (b_cnt != aw_cnt || r_cnt != ar_cnt) @(negedge clk_i);
  endtask

  // Writes to upper rows race reads of filled lower rows in the same bank pair
  task automatic run_concurrent();
    logic [axi_mem_pkg::AXI_ADDR_WIDTH-1:0] waddr [N_CONC];
    logic [axi_mem_pkg::AXI_DATA_WIDTH-1:0] wdata [N_CONC];
    logic [axi_mem_pkg::AXI_ID_WIDTH-1:0]   wid [N_CONC];
    logic [axi_mem_pkg::AXI_ID_WIDTH-1:0]   rid [N_CONC];
    logic [31:0]                            r0, r1, r2;
    // Drawn up front so both streams see a fixed sequence
    for (int i = 0; i < N_CONC; i++) begin
      draw_rand(r0);
      draw_rand(r1);
      draw_rand(r2);
      waddr[i] = {1'b1, r0[10:4], fill_addr[i % N_FILL][3], 3'b000};
      wdata[i] = {r1, r2};
      wid[i]   = r0[3:0];
      rid[i]   = r0[15:12];
    end
    fork
      begin
        for (int i = 0; i < N_CONC; i++) write_beat(waddr[i], wdata[i], 8'hff, wid[i]);
      end
      begin
        for (int i = 0; i < N_CONC; i++) read_beat(fill_addr[i % N_FILL], rid[i]);
      end
    join
    wait_all_done();
    // Upper rows read back once the race has drained
    for (int i = 0; i < N_CONC; i++) begin
      read_beat(waddr[i], wid[i]);
    end
    wait_all_done();
  endtask

  task automatic report_and_finish();
    $display("Errors: data %0d, id %0d, resp %0d, busy %0d, other %0d",
             data_err, id_err, resp_err, busy_err, other_err);
    if (data_err + id_err + resp_err + busy_err + other_err == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  endtask

  // Ready drivers, random when stalls are on
  initial begin
    bready_i = 1'b0;
    rready_i = 1'b0;
    stall_q  = {SEED[15:0], SEED[31:16]};
    forever begin
      @(negedge clk_i);
      stall_q = xorshift32(stall_q);
      if (!rst_n_i) begin
        bready_i = 1'b0;
        rready_i = 1'b0;
      end else if (stall_en) begin
        bready_i = stall_q[4];
        rready_i = stall_q[17];
      end else begin
        bready_i = 1'b1;
        rready_i = 1'b1;
      end
    end
  end

  // Comparing process, everything sampled at the rising edge
  always @(posedge clk_i) begin
    if (rst_n_i) begin
      check_busy("busy_o", {rd_out, wr_out}, busy_o);
      // A stalled response keeps valid, ID and data
      if (prev_bvalid && !prev_bready) begin
        if (!bvalid_o) begin
          other_err++;
          $display("bvalid_o dropped at %0t before bready_i took it", $time);
        end
        check_id("bid_o", prev_bid, bid_o);
      end
      if (prev_rvalid && !prev_rready) begin
        if (!rvalid_o) begin
          other_err++;
          $display("rvalid_o dropped at %0t before rready_i took it", $time);
        end
        check_id("rid_o", prev_rid, rid_o);
        check_data("rdata_o", prev_rdata, rdata_o);
      end
      if (bvalid_o && bready_i) begin
        if (exp_bid_q.size() == 0) begin
          other_err++;
          $display("Write response at %0t with no write outstanding", $time);
        end else begin
          check_id("bid_o", exp_bid_q.pop_front(), bid_o);
        end
        check_resp("bresp_o", axi_mem_pkg::resp_okay, bresp_o);
        b_cnt++;
        wr_out = 1'b0;
      end
      if (rvalid_o && rready_i) begin
        if (exp_rid_q.size() == 0) begin
          other_err++;
          $display("Read response at %0t with no read outstanding", $time);
        end else begin
          check_id("rid_o", exp_rid_q.pop_front(), rid_o);
          check_data("rdata_o", exp_rdata_q.pop_front(), rdata_o);
        end
        check_resp("rresp_o", axi_mem_pkg::resp_okay, rresp_o);
        r_cnt++;
        rd_out = 1'b0;
      end
      // New requests, at most one outstanding per path
      if (awvalid_i && awready_o && wvalid_i && wready_o) begin
        if (wr_out) begin
          other_err++;
          $display("Write accepted at %0t while a write response was pending", $time);
        end
        exp_bid_q.push_back(awid_i);
        merge_write(awaddr_i, wdata_i, wstrb_i);
        aw_cnt++;
        wr_out = 1'b1;
      end
      if (arvalid_i && arready_o) begin
        if (rd_out) begin
          other_err++;
          $display("Read accepted at %0t while a read response was pending", $time);
        end
        exp_rid_q.push_back(arid_i);
        exp_rdata_q.push_back(ref_read(araddr_i));
        ar_cnt++;
        rd_out = 1'b1;
      end
    end
    prev_bvalid = bvalid_o;
    prev_bready = bready_i;
    prev_bid    = bid_o;
    prev_rvalid = rvalid_o;
    prev_rready = rready_i;
    prev_rid    = rid_o;
    prev_rdata  = rdata_o;
  end

  // Cycle limit scaled to the number of transactions
  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      other_err++;
      $display("Timeout after %0d cycles, traffic did not drain", cycle_cnt);
      report_and_finish();
    end
  end

  initial begin
    logic [31:0] r0, r1, r2;
    logic [axi_mem_pkg::AXI_ADDR_WIDTH-1:0] addr;
    rng_q     = SEED;
    stall_en  = 1'b0;
    wr_out    = 1'b0;
    rd_out    = 1'b0;
    cycle_cnt = 0;
    {aw_cnt, b_cnt, ar_cnt, r_cnt} = '0;
    {data_err, id_err, resp_err, busy_err, other_err} = '0;
    {prev_bvalid, prev_bready, prev_rvalid, prev_rready} = '0;
    rst_n_i   = 1'b0;
    awvalid_i = 1'b0;
    awid_i    = '0;
    awaddr_i  = '0;
    wvalid_i  = 1'b0;
    wdata_i   = '0;
    wstrb_i   = '0;
    arvalid_i = 1'b0;
    arid_i    = '0;
    araddr_i  = '0;
    repeat (16) @(negedge clk_i);
    rst_n_i = 1'b1;
    if (awready_o || wready_o || bvalid_o || rvalid_o || busy_o != 2'b00) begin
      other_err++;
      $display("Outputs not idle right after reset");
    end
    @(negedge clk_i);
    if (!arready_o) begin
      other_err++;
      $display("arready_o did not rise in the first cycle after reset");
    end

    // Full strobe fill of lower rows, then read back
    for (int i = 0; i < N_FILL; i++) begin
      draw_rand(r0);
      draw_rand(r1);
      draw_rand(r2);
      fill_addr[i] = {1'b0, r0[10:3], 3'b000};
      write_beat(fill_addr[i], {r1, r2}, 8'hff, r0[15:12]);
    end
    wait_all_done();
    for (int i = 0; i < N_FILL; i++) begin
      draw_rand(r0);
      read_beat(fill_addr[i], r0[3:0]);
    end
    wait_all_done();

    // Partial strobes over filled beats, each read back merged
    for (int i = 0; i < N_MERGE; i++) begin
      draw_rand(r0);
      draw_rand(r1);
      draw_rand(r2);
      addr = fill_addr[r0[31:16] % N_FILL];
      write_beat(addr, {r1, r2}, r0[7:0], r0[11:8]);
      wait_all_done();
      read_beat(addr, r0[15:12]);
      wait_all_done();
    end

    run_concurrent();
    @(posedge clk_i);
    stall_en = 1'b1;
    run_concurrent();
    @(posedge clk_i);
    stall_en = 1'b0;

    // Drained, both responses taken
    repeat (3) @(negedge clk_i);
    check_busy("busy_o", 2'b00, busy_o);
    if (b_cnt != aw_cnt || r_cnt != ar_cnt) begin
      other_err++;
      $display("Lost transactions: %0d writes with %0d B, %0d reads with %0d R",
               aw_cnt, b_cnt, ar_cnt, r_cnt);
    end
    report_and_finish();
  end

endmodule

`default_nettype wire

// File: rtl/axi_mem_banked_top.sv
// Banked AXI memory top
`default_nettype none

module axi_mem_banked_top #(
  parameter int unsigned MEM_LATENCY = 2
) (
  input  wire logic                                   clk_i,
  input  wire logic                                   rst_n_i,
  // Write address
  input  wire logic                                   awvalid_i,
  output logic                                        awready_o,
  input  wire logic [axi_mem_pkg::AXI_ID_WIDTH-1:0]   awid_i,
  input  wire logic [axi_mem_pkg::AXI_ADDR_WIDTH-1:0] awaddr_i,
  // Write data
  input  wire logic                                   wvalid_i,
  output logic                                        wready_o,
  input  wire logic [axi_mem_pkg::AXI_DATA_WIDTH-1:0] wdata_i,
  input  wire logic [axi_mem_pkg::AXI_STRB_WIDTH-1:0] wstrb_i,
  // Write response
  output logic                                        bvalid_o,
  input  wire logic                                   bready_i,
  output logic      [axi_mem_pkg::AXI_ID_WIDTH-1:0]   bid_o,
  output logic      [1:0]                             bresp_o,
  // Read address
  input  wire logic                                   arvalid_i,
  output logic                                        arready_o,
  input  wire logic [axi_mem_pkg::AXI_ID_WIDTH-1:0]   arid_i,
  input  wire logic [axi_mem_pkg::AXI_ADDR_WIDTH-1:0] araddr_i,
  // Read data
  output logic                                        rvalid_o,
  input  wire logic                                   rready_i,
  output logic      [axi_mem_pkg::AXI_ID_WIDTH-1:0]   rid_o,
  output logic      [axi_mem_pkg::AXI_DATA_WIDTH-1:0] rdata_o,
  output logic      [1:0]                             rresp_o,
  // Write busy in bit 0, read busy in bit 1
  output logic      [1:0]                             busy_o
);

  // Ports 0 and 1 write, 2 and 3 read
  mem_port_if port_if [axi_mem_pkg::NUM_PORTS] ();
  mem_bank_if bank_if [axi_mem_pkg::NUM_BANKS] ();

  axi_mem_adapter i_axi_mem_adapter (
    .clk_i,
    .rst_n_i,
    .awvalid_i,
    .awready_o,
    .awid_i,
    .awaddr_i,
    .wvalid_i,
    .wready_o,
    .wdata_i,
    .wstrb_i,
    .bvalid_o,
    .bready_i,
    .bid_o,
    .bresp_o,
    .arvalid_i,
    .arready_o,
    .arid_i,
    .araddr_i,
    .rvalid_o,
    .rready_i,
    .rid_o,
    .rdata_o,
    .rresp_o,
    .busy_o,
    .wr_port ( port_if[0:1] ),
    .rd_port ( port_if[2:3] )
  );

  mem_bank_xbar #(
    .MEM_LATENCY ( MEM_LATENCY )
  ) i_mem_bank_xbar (
    .clk_i,
    .rst_n_i,
    .port ( port_if ),
    .bank ( bank_if )
  );

  // One SRAM per crossbar bank port
  for (genvar b = 0; b < axi_mem_pkg::NUM_BANKS; b++) begin : g_bank
    mem_bank #(
      .MEM_LATENCY ( MEM_LATENCY )
    ) i_mem_bank (
      .clk_i,
      .rst_n_i,
      .bus ( bank_if[b] )
    );
  end

endmodule

`default_nettype wire

// File: rtl/axi_mem_adapter.sv
// AXI to narrow port adapter
`default_nettype none

module axi_mem_adapter (
  input  wire logic                                   clk_i,
  input  wire logic                                   rst_n_i,
  // Write address
  input  wire logic                                   awvalid_i,
  output logic                                        awready_o,
  input  wire logic [axi_mem_pkg::AXI_ID_WIDTH-1:0]   awid_i,
  input  wire logic [axi_mem_pkg::AXI_ADDR_WIDTH-1:0] awaddr_i,
  // Write data
  input  wire logic                                   wvalid_i,
  output logic                                        wready_o,
  input  wire logic [axi_mem_pkg::AXI_DATA_WIDTH-1:0] wdata_i,
  input  wire logic [axi_mem_pkg::AXI_STRB_WIDTH-1:0] wstrb_i,
  // Write response
  output logic                                        bvalid_o,
  input  wire logic                                   bready_i,
  output logic      [axi_mem_pkg::AXI_ID_WIDTH-1:0]   bid_o,
  output logic      [1:0]                             bresp_o,
  // Read address
  input  wire logic                                   arvalid_i,
  output logic                                        arready_o,
  input  wire logic [axi_mem_pkg::AXI_ID_WIDTH-1:0]   arid_i,
  input  wire logic [axi_mem_pkg::AXI_ADDR_WIDTH-1:0] araddr_i,
  // Read data
  output logic                                        rvalid_o,
  input  wire logic                                   rready_i,
  output logic      [axi_mem_pkg::AXI_ID_WIDTH-1:0]   rid_o,
  output logic      [axi_mem_pkg::AXI_DATA_WIDTH-1:0] rdata_o,
  output logic      [1:0]                             rresp_o,
  // Bit 0 write, bit 1 read
  output logic      [1:0]                             busy_o,
  // Narrow ports into the crossbar
  mem_port_if.master                                  wr_port [2],
  mem_port_if.master                                  rd_port [2]
);

  localparam int unsigned MDW  = axi_mem_pkg::MEM_DATA_WIDTH;
  localparam int unsigned MSTRB = axi_mem_pkg::MEM_STRB_WIDTH;

  // Write path
  logic                                   wr_hs;
  logic                                   wr_busy_q;
  logic [1:0]                             wr_req;
  logic [1:0]                             wr_gnt;
  logic [1:0]                             wr_gnt_q;
  logic                                   wr_done;
  logic                                   bvalid_q;
  logic [axi_mem_pkg::AXI_ID_WIDTH-1:0]   wr_id_q;
  axi_mem_pkg::axi_addr_u                 wr_addr_q;
  logic [axi_mem_pkg::AXI_DATA_WIDTH-1:0] wr_data_q;
  logic [axi_mem_pkg::AXI_STRB_WIDTH-1:0] wr_strb_q;

  // Read path
  logic                                   ar_hs;
  logic                                   arready_q;
  logic                                   rd_busy_q;
  logic [1:0]                             rd_req_q;
  logic [1:0]                             rd_gnt;
  logic [1:0]                             rd_ret;
  logic [1:0]                             rd_got_q;
  logic                                   rd_done;
  logic                                   rvalid_q;
  logic [MDW-1:0]                         rd_word [2];
  logic [axi_mem_pkg::AXI_ID_WIDTH-1:0]   rd_id_q;
  axi_mem_pkg::axi_addr_u                 rd_addr_q;
  logic [axi_mem_pkg::AXI_DATA_WIDTH-1:0] rd_data_q;

  // Half h of a beat lives in bank {addr bit 3, h}, word aligned
  function automatic axi_mem_pkg::axi_addr_u half_addr(axi_mem_pkg::axi_addr_u base,
                                                       logic hi);
    axi_mem_pkg::axi_addr_u a;
    a                 = base;
    a.fields.bank[0]  = hi;
    a.fields.byte_off = '0;
    return a;
  endfunction

  // AW and W are taken together, only when the path is idle
  assign wr_hs     = !wr_busy_q && !bvalid_q && awvalid_i && wvalid_i;
  assign awready_o = wr_hs;
  assign wready_o  = wr_hs;

  assign wr_req  = {2{wr_busy_q}} & ~wr_gnt_q;
  // Last grant may arrive in this very cycle
  assign wr_done = wr_busy_q && (&(wr_gnt_q | wr_gnt));

  assign ar_hs     = arready_q && arvalid_i;
  assign arready_o = arready_q;
  assign rd_done   = rd_busy_q && (&(rd_got_q | rd_ret));

  for (genvar h = 0; h < 2; h++) begin : g_half
    // write half with its strobe slice
    assign wr_port[h].req   = wr_req[h];
    assign wr_port[h].addr  = half_addr(wr_addr_q, h == 1);
    assign wr_port[h].we    = 1'b1;
    assign wr_port[h].wdata = wr_data_q[MDW*h +: MDW];
    assign wr_port[h].be    = wr_strb_q[MSTRB*h +: MSTRB];
    assign wr_gnt[h]        = wr_req[h] && wr_port[h].gnt;

    // Read half, no write payload
    assign rd_port[h].req   = rd_req_q[h];
    assign rd_port[h].addr  = half_addr(rd_addr_q, h == 1);
    assign rd_port[h].we    = 1'b0;
    assign rd_port[h].wdata = '0;
    assign rd_port[h].be    = '0;
    assign rd_gnt[h]        = rd_req_q[h] && rd_port[h].gnt;
    assign rd_ret[h]        = rd_port[h].rvalid;
    assign rd_word[h]       = rd_port[h].rdata;
  end

  // Write control
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_busy_q <= 1'b0;
      wr_gnt_q  <= '0;
      bvalid_q  <= 1'b0;
    end else begin
      if (wr_hs) begin
        wr_busy_q <= 1'b1;
        wr_gnt_q  <= '0;
      end else if (wr_done) begin
        wr_busy_q <= 1'b0;
        bvalid_q  <= 1'b1;
      end else begin
        wr_gnt_q <= wr_gnt_q | wr_gnt;
      end
      // B held until taken
      if (bvalid_q && bready_i) begin
        bvalid_q <= 1'b0;
      end
    end
  end

  // Read control
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      arready_q <= 1'b0;
      rd_busy_q <= 1'b0;
      rd_req_q  <= '0;
      rd_got_q  <= '0;
      rvalid_q  <= 1'b0;
    end else begin
      // Ready again once R leaves the path
      if (ar_hs) begin
        arready_q <= 1'b0;
      end else if (!rd_busy_q && (!rvalid_q || rready_i)) begin
        arready_q <= 1'b1;
      end
      if (ar_hs) begin
        rd_busy_q <= 1'b1;
        rd_req_q  <= 2'b11;
        rd_got_q  <= '0;
      end else if (rd_done) begin
        rd_busy_q <= 1'b0;
        rvalid_q  <= 1'b1;
      end else begin
        // drop each request on its grant
        rd_req_q <= rd_req_q & ~rd_gnt;
        rd_got_q <= rd_got_q | rd_ret;
      end
      if (rvalid_q && rready_i) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  // Payload registers
  always_ff @(posedge clk_i) begin
    if (wr_hs) begin
      wr_id_q        <= awid_i;
      wr_addr_q.flat <= awaddr_i;
      wr_data_q      <= wdata_i;
      wr_strb_q      <= wstrb_i;
    end
    if (ar_hs) begin
      rd_id_q        <= arid_i;
      rd_addr_q.flat <= araddr_i;
    end
    // Returning words fill low or high half
    for (int h = 0; h < 2; h++) begin
      if (rd_ret[h]) begin
        rd_data_q[MDW*h +: MDW] <= rd_word[h];
      end
    end
  end

  // Responses, always OKAY
  assign bvalid_o = bvalid_q;
  assign bid_o    = wr_id_q;
  assign bresp_o  = axi_mem_pkg::resp_okay;
  assign rvalid_o = rvalid_q;
  assign rid_o    = rd_id_q;
  assign rdata_o  = rd_data_q;
  assign rresp_o  = axi_mem_pkg::resp_okay;

  assign busy_o = {rd_busy_q | rvalid_q, wr_busy_q | bvalid_q};

endmodule

`default_nettype wire

// File: rtl/mem_bank_xbar.sv
// Logarithmic bank crossbar
`default_nettype none

module mem_bank_xbar #(
  parameter int unsigned MEM_LATENCY = 2
) (
  input  wire logic  clk_i,
  input  wire logic  rst_n_i,
  mem_port_if.slave  port [axi_mem_pkg::NUM_PORTS],
  mem_bank_if.master bank [axi_mem_pkg::NUM_BANKS]
);

  localparam int unsigned NP         = axi_mem_pkg::NUM_PORTS;
  localparam int unsigned NB         = axi_mem_pkg::NUM_BANKS;
  localparam int unsigned MDW        = axi_mem_pkg::MEM_DATA_WIDTH;
  localparam int unsigned PORT_SEL_W = $clog2(NP);

  // Flattened port side
  logic [NP-1:0]                          p_req;
  axi_mem_pkg::axi_addr_u                 p_addr [NP];
  logic [NP-1:0]                          p_we;
  logic [MDW-1:0]                         p_wdata [NP];
  logic [axi_mem_pkg::MEM_STRB_WIDTH-1:0] p_be [NP];
  logic [NP-1:0]                          p_gnt;
  logic [NP-1:0]                          p_rvalid;
  logic [MDW-1:0]                         p_rdata [NP];

  // Per bank arbitration
  logic [NP-1:0]         bank_req [NB];
  logic [NB-1:0]         win_vld;
  logic [PORT_SEL_W-1:0] win_idx [NB];
  logic [PORT_SEL_W-1:0] rr_q [NB];
  logic [MDW-1:0]        b_rdata [NB];

  // Read ownership, one entry per latency stage
  logic                  ret_vld_q [NB][MEM_LATENCY];
  logic [PORT_SEL_W-1:0] ret_port_q [NB][MEM_LATENCY];

  for (genvar p = 0; p < NP; p++) begin : g_port
    assign p_req[p]       = port[p].req;
    assign p_addr[p]      = port[p].addr;
    assign p_we[p]        = port[p].we;
    assign p_wdata[p]     = port[p].wdata;
    assign p_be[p]        = port[p].be;
    assign port[p].gnt    = p_gnt[p];
    assign port[p].rvalid = p_rvalid[p];
    assign port[p].rdata  = p_rdata[p];
  end

  // Round robin search starting at each bank's pointer
  always_comb begin
    logic [PORT_SEL_W-1:0] cand;
    cand  = '0;
    p_gnt = '0;
    for (int b = 0; b < NB; b++) begin
      for (int p = 0; p < NP; p++) begin
        bank_req[b][p] = p_req[p] && (p_addr[p].fields.bank == b);
      end
      win_vld[b] = 1'b0;
      win_idx[b] = '0;
      for (int i = 0; i < NP; i++) begin
        cand = PORT_SEL_W'(rr_q[b] + i);
        if (!win_vld[b] && bank_req[b][cand]) begin
          win_vld[b] = 1'b1;
          win_idx[b] = cand;
        end
      end
      // A port targets one bank, so grants never collide
      if (win_vld[b]) begin
        p_gnt[win_idx[b]] = 1'b1;
      end
    end
  end

  // Winner's request goes to the bank
  for (genvar b = 0; b < NB; b++) begin : g_bank
    assign bank[b].req   = win_vld[b];
    assign bank[b].row   = p_addr[win_idx[b]].fields.row;
    assign bank[b].we    = p_we[win_idx[b]];
    assign bank[b].wdata = p_wdata[win_idx[b]];
    assign bank[b].be    = p_be[win_idx[b]];
    assign b_rdata[b]    = bank[b].rdata;
  end

  // Pointer moves past each winner, reads enter the return pipe
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int b = 0; b < NB; b++) begin
        rr_q[b] <= '0;
        for (int s = 0; s < MEM_LATENCY; s++) begin
          ret_vld_q[b][s]  <= 1'b0;
          ret_port_q[b][s] <= '0;
        end
      end
    end else begin
      for (int b = 0; b < NB; b++) begin
        if (win_vld[b]) begin
          rr_q[b] <= win_idx[b] + 1'b1;
        end
        ret_vld_q[b][0]  <= win_vld[b] && !p_we[win_idx[b]];
        ret_port_q[b][0] <= win_idx[b];
        for (int s = 1; s < MEM_LATENCY; s++) begin
          ret_vld_q[b][s]  <= ret_vld_q[b][s-1];
          ret_port_q[b][s] <= ret_port_q[b][s-1];
        end
      end
    end
  end

  // Route bank data back to its owner at the end of the pipe
  always_comb begin
    p_rvalid = '0;
    for (int p = 0; p < NP; p++) begin
      p_rdata[p] = '0;
    end
    for (int b = 0; b < NB; b++) begin
      if (ret_vld_q[b][MEM_LATENCY-1]) begin
        p_rvalid[ret_port_q[b][MEM_LATENCY-1]] = 1'b1;
        p_rdata[ret_port_q[b][MEM_LATENCY-1]]  = b_rdata[b];
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/mem_bank.sv
// Byte enabled SRAM bank
`default_nettype none

module mem_bank #(
  parameter int unsigned MEM_LATENCY = 2
) (
  input  wire logic clk_i,
  input  wire logic rst_n_i,
  mem_bank_if.slave bus
);

  localparam int unsigned MDW       = axi_mem_pkg::MEM_DATA_WIDTH;
  localparam int unsigned NUM_WORDS = 2 ** axi_mem_pkg::MEM_ROW_WIDTH;

  logic [MDW-1:0] mem_q [NUM_WORDS];
  // Read delay line, last stage drives rdata
  logic [MDW-1:0] dly_q [MEM_LATENCY];

  // Storage, only enabled bytes change
  always_ff @(posedge clk_i) begin
    if (bus.req && bus.we) begin
      for (int i = 0; i < axi_mem_pkg::MEM_STRB_WIDTH; i++) begin
        if (bus.be[i]) begin
          mem_q[bus.row][8*i +: 8] <= bus.wdata[8*i +: 8];
        end
      end
    end
  end

  // One register per latency cycle
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int s = 0; s < MEM_LATENCY; s++) begin
        dly_q[s] <= '0;
      end
    end else begin
      // Idle cycles push zeros
      dly_q[0] <= (bus.req && !bus.we) ? mem_q[bus.row] : '0;
      for (int s = 1; s < MEM_LATENCY; s++) begin
        dly_q[s] <= dly_q[s-1];
      end
    end
  end

  assign bus.rdata = dly_q[MEM_LATENCY-1];

endmodule

`default_nettype wire

// File: rtl/mem_bank_if.sv
// Single SRAM bank port
`default_nettype none

interface mem_bank_if;

  // Accepted in the cycle it is presented
  logic                                   req;
  logic [axi_mem_pkg::MEM_ROW_WIDTH-1:0]  row;
  logic                                   we;
  logic [axi_mem_pkg::MEM_DATA_WIDTH-1:0] wdata;
  logic [axi_mem_pkg::MEM_STRB_WIDTH-1:0] be;
  // Valid MEM_LATENCY cycles after a read
  logic [axi_mem_pkg::MEM_DATA_WIDTH-1:0] rdata;

  // Crossbar side
  modport master (
    output req, row, we, wdata, be,
    input  rdata
  );

  // Bank side
  modport slave (
    input  req, row, we, wdata, be,
    output rdata
  );

endinterface

`default_nettype wire

// File: rtl/mem_port_if.sv
// Narrow memory port
`default_nettype none

interface mem_port_if;

  // Request, held by the master until gnt
  logic                                   req;
  logic                                   gnt;
  axi_mem_pkg::axi_addr_u                 addr;
  logic                                   we;
  logic [axi_mem_pkg::MEM_DATA_WIDTH-1:0] wdata;
  logic [axi_mem_pkg::MEM_STRB_WIDTH-1:0] be;

  // Read return, single cycle pulse with no ready
  logic                                   rvalid;
  logic [axi_mem_pkg::MEM_DATA_WIDTH-1:0] rdata;

  // Adapter side
  modport master (
    output req, addr, we, wdata, be,
    input  gnt, rvalid, rdata
  );

  // Crossbar side
  modport slave (
    input  req, addr, we, wdata, be,
    output gnt, rvalid, rdata
  );

endinterface

`default_nettype wire

// File: rtl/axi_mem_pkg.sv
// AXI banked memory definitions
`default_nettype none

package axi_mem_pkg;

  // AXI side widths
  localparam int unsigned AXI_ID_WIDTH   = 4;
  localparam int unsigned AXI_DATA_WIDTH = 64;
  localparam int unsigned AXI_ADDR_WIDTH = 12;
  localparam int unsigned AXI_STRB_WIDTH = AXI_DATA_WIDTH / 8;

  // Bank word and geometry
  localparam int unsigned MEM_DATA_WIDTH = 32;
  localparam int unsigned MEM_STRB_WIDTH = MEM_DATA_WIDTH / 8;
  // Power of two, word interleaved
  localparam int unsigned NUM_BANKS      = 4;
  localparam int unsigned MEM_ROW_WIDTH  = 8;
  localparam int unsigned BANK_SEL_WIDTH = $clog2(NUM_BANKS);
  localparam int unsigned BYTE_OFF_WIDTH = $clog2(MEM_STRB_WIDTH);

  // Ports 0 and 1 carry writes, ports 2 and 3 carry reads
  localparam int unsigned NUM_PORTS      = 4;

  // One address word, seen flat or split into bank fields
  typedef union packed {
    logic [AXI_ADDR_WIDTH-1:0] flat;
    struct packed {
      logic [MEM_ROW_WIDTH-1:0]  row;
      logic [BANK_SEL_WIDTH-1:0] bank;
      logic [BYTE_OFF_WIDTH-1:0] byte_off;
    } fields;
  } axi_addr_u;

  // Only response ever returned
  localparam logic [1:0] resp_okay = 2'b00;

endpackage

`default_nettype wire
